// File: common/hps_cmd_pkg.sv
// Host command opcodes and the host data word type
`default_nettype none

package hps_cmd_pkg;

	// Host port data word
	localparam int IO_W = 16;

	// Opcode field in the first word of a command
	localparam int CMD_W = 8;

	typedef logic [IO_W-1:0] io_word_t;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes decoded by the video register bank
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [CMD_W-1:0] {
		// 8 words of video timing
		CMD_VIDEO_TIMING = 8'h20,
		// Output height override
		CMD_VSET         = 8'h27,
		// Output width override, bit 15 is free scaling
		CMD_HSET         = 8'h37,
		// Two custom aspect pairs
		CMD_AR_CUSTOM    = 8'h3A
	} hps_cmd_e;

endpackage

`default_nettype wire

// File: common/video_pkg.sv
// Coordinate width, video timing, aspect, window config and window types
`default_nettype none

package video_pkg;

	localparam int COORD_W = 12;

	// Aspect components carry one extra flag bit on top
	localparam int ASPECT_W = COORD_W + 1;

	typedef logic [COORD_W-1:0] coord_t;

	typedef struct packed {
		coord_t width;
		coord_t hfp;
		coord_t hs;
		coord_t hbp;
		coord_t height;
		coord_t vfp;
		coord_t vs;
		coord_t vbp;
	} video_timing_t;

	// Bit 12 set on either part means exact pixel size
	typedef struct packed {
		logic [ASPECT_W-1:0] x;
		logic [ASPECT_W-1:0] y;
	} aspect_t;

	typedef struct packed {
		video_timing_t timing;
		coord_t        vset;
		coord_t        hset;
		logic          freescale;
		aspect_t       arc1;
		aspect_t       arc2;
	} win_cfg_t;

	typedef struct packed {
		coord_t hmin;
		coord_t hmax;
		coord_t vmin;
		coord_t vmax;
	} window_t;

endpackage

`default_nettype wire

// File: hps_io/hps_cmd_decoder.sv
// Host port synchronizer, strobe detection and command / word index tracking
`timescale 1ns/1ns
`default_nettype none

module hps_cmd_decoder (
	input  logic                  clk_sys,
	input  logic                  resetd,

	input  logic                  i_io_clk,
	input  logic                  i_io_uio,
	input  hps_cmd_pkg::io_word_t i_io_din,
	output logic                  o_io_ack,

	output logic                  o_wr,
	output hps_cmd_pkg::hps_cmd_e o_wr_cmd,
	output logic [3:0]            o_wr_idx,
	output hps_cmd_pkg::io_word_t o_wr_data
);
	import hps_cmd_pkg::*;

	logic [1:0] clk_sync;
	logic [1:0] uio_sync;
	io_word_t   din_s1;
	io_word_t   din_s2;
	logic       strobe;
	logic       has_cmd;

	////////////////////////////////////////////////////////////////////////////
	// Host line synchronizers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_sync <= '0;
			uio_sync <= '0;
			o_io_ack <= 1'b0;
		end else begin
			clk_sync <= {clk_sync[0], i_io_clk};
			uio_sync <= {uio_sync[0], i_io_uio};
			// Ack echoes the host clock level one cycle late
			o_io_ack <= clk_sync[1];
		end
	end

	// Data word kept in step with the clock line
	always_ff @(posedge clk_sys) begin
		din_s1 <= i_io_din;
		din_s2 <= din_s1;
	end

	// Rising edge of the host clock, ack still low
	assign strobe = clk_sync[1] & ~o_io_ack & uio_sync[1];

	////////////////////////////////////////////////////////////////////////////
	// Opcode and word index
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd  <= 1'b0;
			o_wr_cmd <= hps_cmd_e'(CMD_W'(0));
			o_wr_idx <= '0;
		end else if (!uio_sync[1]) begin
			has_cmd  <= 1'b0;
			o_wr_cmd <= hps_cmd_e'(CMD_W'(0));
			o_wr_idx <= '0;
		end else if (strobe) begin
			if (!has_cmd) begin
				// First word after uio rises is the opcode
				has_cmd  <= 1'b1;
				o_wr_cmd <= hps_cmd_e'(din_s2[CMD_W-1:0]);
				o_wr_idx <= '0;
			end else if (o_wr_idx != 4'hF) begin
				// Saturate, no command uses that many words
				o_wr_idx <= o_wr_idx + 4'd1;
			end
		end
	end

	// One write per data word, index is the one before the increment
	assign o_wr      = strobe & has_cmd;
	assign o_wr_data = din_s2;

endmodule

`default_nettype wire

// File: hps_io/video_cfg_regs.sv
// Video timing, output size override and custom aspect register bank
`timescale 1ns/1ns
`default_nettype none

module video_cfg_regs (
	input  logic                  clk_sys,
	input  logic                  resetd,

	input  logic                  i_wr,
	input  hps_cmd_pkg::hps_cmd_e i_wr_cmd,
	input  logic [3:0]            i_wr_idx,
	input  hps_cmd_pkg::io_word_t i_wr_data,

	output video_pkg::win_cfg_t   o_cfg
);
	import hps_cmd_pkg::*;
	import video_pkg::*;

	// 1920x1080 at 60 Hz
	localparam video_timing_t TIMING_RESET = '{
		width:  12'd1920,
		hfp:    12'd88,
		hs:     12'd48,
		hbp:    12'd148,
		height: 12'd1080,
		vfp:    12'd4,
		vs:     12'd5,
		vbp:    12'd36
	};

	localparam win_cfg_t CFG_RESET = '{
		timing:    TIMING_RESET,
		vset:      '0,
		hset:      '0,
		freescale: 1'b0,
		arc1:      '0,
		arc2:      '0
	};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_cfg <= CFG_RESET;
		end else if (i_wr) begin
			case (i_wr_cmd)
				CMD_VIDEO_TIMING: begin
					case (i_wr_idx)
						4'd0: o_cfg.timing.width  <= i_wr_data[COORD_W-1:0];
						4'd1: o_cfg.timing.hfp    <= i_wr_data[COORD_W-1:0];
						4'd2: o_cfg.timing.hs     <= i_wr_data[COORD_W-1:0];
						4'd3: o_cfg.timing.hbp    <= i_wr_data[COORD_W-1:0];
						4'd4: o_cfg.timing.height <= i_wr_data[COORD_W-1:0];
						4'd5: o_cfg.timing.vfp    <= i_wr_data[COORD_W-1:0];
						4'd6: o_cfg.timing.vs     <= i_wr_data[COORD_W-1:0];
						4'd7: o_cfg.timing.vbp    <= i_wr_data[COORD_W-1:0];
						default: ;
					endcase
				end
				CMD_VSET: begin
					if (i_wr_idx == 4'd0)
						o_cfg.vset <= i_wr_data[COORD_W-1:0];
				end
				CMD_HSET: begin
					if (i_wr_idx == 4'd0) begin
						o_cfg.freescale <= i_wr_data[IO_W-1];
						o_cfg.hset      <= i_wr_data[COORD_W-1:0];
					end
				end
				CMD_AR_CUSTOM: begin
					case (i_wr_idx)
						4'd0: o_cfg.arc1.x <= i_wr_data[ASPECT_W-1:0];
						4'd1: o_cfg.arc1.y <= i_wr_data[ASPECT_W-1:0];
						4'd2: o_cfg.arc2.x <= i_wr_data[ASPECT_W-1:0];
						4'd3: o_cfg.arc2.y <= i_wr_data[ASPECT_W-1:0];
						default: ;
					endcase
				end
				// Unknown opcodes are dropped
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: video_window/umuldiv.sv
// Iterative unsigned multiply then restoring divide, one quotient bit per cycle
`timescale 1ns/1ns
`default_nettype none

module umuldiv #(
	parameter int DIV_STEPS = 24
) (
	input  logic              clk_sys,
	input  logic              resetd,

	input  logic              i_start,
	input  video_pkg::coord_t i_mul1,
	input  video_pkg::coord_t i_mul2,
	input  video_pkg::coord_t i_div,

	output logic              o_busy,
	output video_pkg::coord_t o_result
);
	import video_pkg::*;

	localparam int CNT_W = $clog2(DIV_STEPS + 1);

	logic [2*COORD_W-1:0] product;
	logic [DIV_STEPS-1:0] num;
	logic [CNT_W-1:0]     step_cnt;
	coord_t               rem;
	coord_t               divisor;
	logic [COORD_W:0]     rem_sh;
	logic                 fits;

	assign product = i_mul1 * i_mul2;
	assign rem_sh  = {rem, num[DIV_STEPS-1]};
	assign fits    = rem_sh >= {1'b0, divisor};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy   <= 1'b0;
			step_cnt <= '0;
		end else if (i_start && !o_busy) begin
			o_busy   <= 1'b1;
			step_cnt <= CNT_W'(DIV_STEPS);
		end else if (o_busy) begin
			// Extra cycle at zero to load the result
			if (step_cnt != '0)
				step_cnt <= step_cnt - 1'b1;
			else
				o_busy <= 1'b0;
		end
	end

	// Quotient bits shift into num as the dividend shifts out
	always_ff @(posedge clk_sys) begin
		if (i_start && !o_busy) begin
			num     <= DIV_STEPS'(product);
			rem     <= '0;
			divisor <= i_div;
		end else if (o_busy) begin
			if (step_cnt != '0) begin
				rem <= fits ? COORD_W'(rem_sh - {1'b0, divisor}) : rem_sh[COORD_W-1:0];
				num <= {num[DIV_STEPS-2:0], fits};
			end else begin
				o_result <= num[COORD_W-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: video_window/ar_window_fsm.sv
// Looping state machine computing the centered display window
`timescale 1ns/1ns
`default_nettype none

module ar_window_fsm (
	input  logic                clk_sys,
	input  logic                resetd,

	input  video_pkg::win_cfg_t i_cfg,
	input  video_pkg::aspect_t  i_ar,

	input  logic                i_md_busy,
	input  video_pkg::coord_t   i_md_res,
	output logic                o_md_start,
	output video_pkg::coord_t   o_md_mul1,
	output video_pkg::coord_t   o_md_mul2,
	output video_pkg::coord_t   o_md_div,

	output video_pkg::window_t  o_window
);
	import video_pkg::*;

	typedef enum logic [2:0] {
		SELECT,
		MUL_W,
		WAIT_W,
		MUL_H,
		WAIT_H,
		CLAMP,
		CENTER
	} state_e;

	state_e  state;
	coord_t  out_w;
	coord_t  out_h;
	aspect_t ar_eff;
	logic    ar_exact;
	logic    ar_zero;
	logic    md_done;
	coord_t  sz_w;
	coord_t  sz_h;
	coord_t  scr_w;
	coord_t  scr_h;
	coord_t  ar_x;
	coord_t  ar_y;
	coord_t  wcalc;
	coord_t  hcalc;
	coord_t  videow;
	coord_t  videoh;
	coord_t  h_off;
	coord_t  v_off;

	// Override only when smaller than the active area
	always_comb begin
		out_h = (i_cfg.vset != '0 && i_cfg.vset < i_cfg.timing.height) ?
			i_cfg.vset : i_cfg.timing.height;
		out_w = (i_cfg.hset != '0 && i_cfg.hset < i_cfg.timing.width) ?
			i_cfg.hset : i_cfg.timing.width;
	end

	// Core ratio, or custom pair 1 / 2 when y is zero
	always_comb begin
		if (i_ar.y != '0)
			ar_eff = i_ar;
		else if (i_ar.x == ASPECT_W'(1))
			ar_eff = i_cfg.arc1;
		else if (i_ar.x == ASPECT_W'(2))
			ar_eff = i_cfg.arc2;
		else
			ar_eff = '0;
	end

	assign ar_exact = ar_eff.x[ASPECT_W-1] | ar_eff.y[ASPECT_W-1];
	assign ar_zero  = (ar_eff.x[COORD_W-1:0] == '0) || (ar_eff.y[COORD_W-1:0] == '0);
	assign md_done  = ~o_md_start & ~i_md_busy;
	assign h_off    = (scr_w - videow) >> 1;
	assign v_off    = (scr_h - videoh) >> 1;

	////////////////////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state      <= SELECT;
			o_md_start <= 1'b0;
			o_window   <= '0;
		end else begin
			o_md_start <= 1'b0;
			case (state)
				SELECT: begin
					if (i_cfg.freescale || ar_zero || ar_exact)
						state <= CLAMP;
					else
						state <= MUL_W;
				end
				MUL_W: begin
					o_md_start <= 1'b1;
					state      <= WAIT_W;
				end
				WAIT_W: if (md_done) state <= MUL_H;
				MUL_H: begin
					o_md_start <= 1'b1;
					state      <= WAIT_H;
				end
				WAIT_H: if (md_done) state <= CLAMP;
				CLAMP:  state <= CENTER;
				CENTER: begin
					o_window.hmin <= h_off;
					o_window.hmax <= h_off + videow - COORD_W'(1);
					o_window.vmin <= v_off;
					o_window.vmax <= v_off + videoh - COORD_W'(1);
					state         <= SELECT;
				end
				default: state <= SELECT;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		case (state)
			SELECT: begin
				// Snapshot for the whole pass
				sz_w  <= out_w;
				sz_h  <= out_h;
				scr_w <= i_cfg.timing.width;
				scr_h <= i_cfg.timing.height;
				ar_x  <= ar_eff.x[COORD_W-1:0];
				ar_y  <= ar_eff.y[COORD_W-1:0];
				if (i_cfg.freescale || ar_zero) begin
					wcalc <= out_w;
					hcalc <= out_h;
				end else if (ar_exact) begin
					wcalc <= ar_eff.x[COORD_W-1:0];
					hcalc <= ar_eff.y[COORD_W-1:0];
				end
			end
			MUL_W: begin
				o_md_mul1 <= sz_h;
				o_md_mul2 <= ar_x;
				o_md_div  <= ar_y;
			end
			WAIT_W: if (md_done) wcalc <= i_md_res;
			MUL_H: begin
				o_md_mul1 <= sz_w;
				o_md_mul2 <= ar_y;
				o_md_div  <= ar_x;
			end
			WAIT_H: if (md_done) hcalc <= i_md_res;
			CLAMP: begin
				videow <= (wcalc > sz_w) ? sz_w : wcalc;
				videoh <= (hcalc > sz_h) ? sz_h : hcalc;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/sys_video_ctrl.sv
// Top level joining host decoder, register bank, window FSM and divider
`timescale 1ns/1ns
`default_nettype none

module sys_video_ctrl #(
	parameter int DIV_STEPS = 24
) (
	input  logic                  clk_sys,
	input  logic                  resetd,

	input  logic                  i_io_clk,
	input  logic                  i_io_uio,
	input  hps_cmd_pkg::io_word_t i_io_din,
	input  video_pkg::aspect_t    i_ar,

	output logic                  o_io_ack,
	output video_pkg::window_t    o_window
);
	import hps_cmd_pkg::*;
	import video_pkg::*;

	logic       wr;
	hps_cmd_e   wr_cmd;
	logic [3:0] wr_idx;
	io_word_t   wr_data;
	win_cfg_t   cfg;
	logic       md_start;
	logic       md_busy;
	coord_t     md_mul1;
	coord_t     md_mul2;
	coord_t     md_div;
	coord_t     md_res;

	hps_cmd_decoder decoder_i (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_io_clk  (i_io_clk),
		.i_io_uio  (i_io_uio),
		.i_io_din  (i_io_din),
		.o_io_ack  (o_io_ack),
		.o_wr      (wr),
		.o_wr_cmd  (wr_cmd),
		.o_wr_idx  (wr_idx),
		.o_wr_data (wr_data)
	);

	video_cfg_regs regs_i (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_wr      (wr),
		.i_wr_cmd  (wr_cmd),
		.i_wr_idx  (wr_idx),
		.i_wr_data (wr_data),
		.o_cfg     (cfg)
	);

	ar_window_fsm window_i (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_cfg      (cfg),
		.i_ar       (i_ar),
		.i_md_busy  (md_busy),
		.i_md_res   (md_res),
		.o_md_start (md_start),
		.o_md_mul1  (md_mul1),
		.o_md_mul2  (md_mul2),
		.o_md_div   (md_div),
		.o_window   (o_window)
	);

	umuldiv #(
		.DIV_STEPS (DIV_STEPS)
	) muldiv_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

endmodule

`default_nettype wire

// File: verification/sys_video_ctrl_assertions.sv
// Host port, window and divider protocol assertions bound to sys_video_ctrl
`timescale 1ns/1ns
`default_nettype none

module sys_video_ctrl_assertions (
	input  logic               clk_sys,
	input  logic               resetd,

	input  logic               i_io_clk,
	input  logic               i_io_ack,
	input  video_pkg::window_t i_window,
	input  logic               i_md_start,
	input  logic               i_md_busy
);
	import video_pkg::*;

	int unsigned fail_count;

	initial fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// Reset and host port
	////////////////////////////////////////////////////////////////////////////

	a_reset_values: assert property (
		@(posedge clk_sys) resetd |=> (!i_io_ack && i_window == '0)
	) else begin
		$error("o_io_ack or o_window not zero after reset");
		fail_count++;
	end

	// Ack lags the host clock by two sync flops and its own register
	a_ack_follows_clk: assert property (
		@(posedge clk_sys) disable iff (resetd)
		$changed(i_io_ack) |-> (i_io_ack == $past(i_io_clk, 3))
	) else begin
		$error("o_io_ack changed without a matching i_io_clk change");
		fail_count++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Window and divider
	////////////////////////////////////////////////////////////////////////////

	a_window_order: assert property (
		@(posedge clk_sys) disable iff (resetd)
		(i_window != '0) |->
			(i_window.hmin <= i_window.hmax && i_window.vmin <= i_window.vmax)
	) else begin
		$error("window min above max");
		fail_count++;
	end

	a_busy_after_start: assert property (
		@(posedge clk_sys) disable iff (resetd)
		$rose(i_md_busy) |-> $past(i_md_start)
	) else begin
		$error("divider busy rose without start");
		fail_count++;
	end

endmodule

`default_nettype wire

// File: verification/tb_sys_video_ctrl.sv
// Testbench for sys_video_ctrl with clock, reset, host command stimulus and window checks
`timescale 1ns/1ns
`default_nettype none

module tb_sys_video_ctrl;
	import hps_cmd_pkg::*;
	import video_pkg::*;

	localparam int DIV_STEPS   = 24;
	localparam int ACK_TIMEOUT = 20;
	localparam int SETTLE      = 128;

	logic     clk_sys;
	logic     resetd;
	logic     io_clk;
	logic     io_uio;
	io_word_t io_din;
	aspect_t  ar;
	logic     io_ack;
	window_t  window;

	// Host side copy of the register bank
	coord_t   m_width;
	coord_t   m_height;
	coord_t   m_vset;
	coord_t   m_hset;
	logic     m_free;
	aspect_t  m_arc1;
	aspect_t  m_arc2;

	sys_video_ctrl #(
		.DIV_STEPS (DIV_STEPS)
	) sys_video_ctrl_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_clk (io_clk),
		.i_io_uio (io_uio),
		.i_io_din (io_din),
		.i_ar     (ar),
		.o_io_ack (io_ack),
		.o_window (window)
	);

	bind sys_video_ctrl sys_video_ctrl_assertions sva_i (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_io_clk   (i_io_clk),
		.i_io_ack   (o_io_ack),
		.i_window   (o_window),
		.i_md_start (md_start),
		.i_md_busy  (md_busy)
	);

	always #4 clk_sys = ~clk_sys;

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	// Bound assertions count their failures
	always @(negedge clk_sys) begin
		if (sys_video_ctrl_i.sva_i.fail_count != 0) begin
			$display("A bound assertion in sys_video_ctrl_assertions failed");
			stop_run();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Host port
	////////////////////////////////////////////////////////////////////////////

	task automatic set_io_clk(input logic level);
		int waited;
		waited = 0;
		io_clk = level;
		while (io_ack != level) begin
			next_cycle();
			waited++;
			if (waited > ACK_TIMEOUT) begin
				$display("Timeout: o_io_ack did not follow i_io_clk to level %0d", level);
				stop_run();
			end
		end
	endtask

	// One word per full toggle of the host clock
	task automatic send_word(input io_word_t word);
		io_din = word;
		set_io_clk(1'b1);
		set_io_clk(1'b0);
	endtask

	task automatic begin_cmd(input logic [7:0] op);
		io_uio = 1'b1;
		next_cycle();
		send_word({8'h00, op});
	endtask

	task automatic end_cmd();
		io_uio = 1'b0;
		repeat (3) next_cycle();
	endtask

	task automatic write_timing(input coord_t w, input coord_t h);
		begin_cmd(CMD_VIDEO_TIMING);
		send_word({4'h0, w});
		send_word(16'd110);
		send_word(16'd40);
		send_word(16'd220);
		send_word({4'h0, h});
		send_word(16'd5);
		send_word(16'd5);
		send_word(16'd20);
		end_cmd();
		m_width  = w;
		m_height = h;
	endtask

	task automatic write_vset(input coord_t v);
		begin_cmd(CMD_VSET);
		send_word({4'h0, v});
		end_cmd();
		m_vset = v;
	endtask

	task automatic write_hset(input logic free, input coord_t h);
		begin_cmd(CMD_HSET);
		send_word({free, 3'b000, h});
		end_cmd();
		m_free = free;
		m_hset = h;
	endtask

	task automatic write_arc(input aspect_t a1, input aspect_t a2);
		begin_cmd(CMD_AR_CUSTOM);
		send_word({3'b000, a1.x});
		send_word({3'b000, a1.y});
		send_word({3'b000, a2.x});
		send_word({3'b000, a2.y});
		end_cmd();
		m_arc1 = a1;
		m_arc2 = a2;
	endtask

	task automatic random_ratio();
		ar.x = 13'($urandom_range(15, 1));
		ar.y = 13'($urandom_range(15, 1));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Expected window
	////////////////////////////////////////////////////////////////////////////

	function automatic window_t expected_window();
		coord_t      oh;
		coord_t      ow;
		coord_t      wcalc;
		coord_t      hcalc;
		coord_t      vw;
		coord_t      vh;
		aspect_t     a;
		logic [23:0] prod;
		window_t     exp;
		oh = (m_vset != '0 && m_vset < m_height) ? m_vset : m_height;
		ow = (m_hset != '0 && m_hset < m_width) ? m_hset : m_width;
		if (ar.y != '0)
			a = ar;
		else if (ar.x == 13'd1)
			a = m_arc1;
		else if (ar.x == 13'd2)
			a = m_arc2;
		else
			a = '0;
		if (m_free || a.x == '0 || a.y == '0) begin
			wcalc = ow;
			hcalc = oh;
		end else if (a.x[12] || a.y[12]) begin
			wcalc = a.x[11:0];
			hcalc = a.y[11:0];
		end else begin
			// Quotients keep only their low 12 bits
			prod  = 24'(oh) * 24'(a.x[11:0]);
			wcalc = 12'(prod / 24'(a.y[11:0]));
			prod  = 24'(ow) * 24'(a.y[11:0]);
			hcalc = 12'(prod / 24'(a.x[11:0]));
		end
		vw = (wcalc < ow) ? wcalc : ow;
		vh = (hcalc < oh) ? hcalc : oh;
		exp.hmin = (m_width - vw) >> 1;
		exp.hmax = exp.hmin + vw - 12'd1;
		exp.vmin = (m_height - vh) >> 1;
		exp.vmax = exp.vmin + vh - 12'd1;
		return exp;
	endfunction

	task automatic check_window(input window_t exp);
		assert (window == exp) else begin
			$display("ERROR o_window: hmin=%h hmax=%h vmin=%h vmax=%h",
				window.hmin, window.hmax, window.vmin, window.vmax);
			$display("ERROR o_window expected: hmin=%h hmax=%h vmin=%h vmax=%h",
				exp.hmin, exp.hmax, exp.vmin, exp.vmax);
			stop_run();
		end
	endtask

	// Two full passes of the window FSM fit in this time
	task automatic settle_and_check();
		repeat (SETTLE) next_cycle();
		check_window(expected_window());
	endtask

	initial begin
		int n;
		void'($urandom(13));
		clk_sys  = 1'b0;
		resetd   = 1'b1;
		io_clk   = 1'b0;
		io_uio   = 1'b0;
		io_din   = '0;
		ar       = '0;
		m_width  = 12'd1920;
		m_height = 12'd1080;
		m_vset   = '0;
		m_hset   = '0;
		m_free   = 1'b0;
		m_arc1   = '0;
		m_arc2   = '0;
		repeat (3) next_cycle();
		resetd = 1'b0;

		// Defaults give the full 1920x1080 screen
		settle_and_check();

		// 3:10 truncates the height quotient past 4095
		write_timing(12'd1280, 12'd720);
		ar = '{x: 13'd3, y: 13'd10};
		settle_and_check();
		for (n = 0; n < 3; n++) begin
			random_ratio();
			settle_and_check();
		end

		// Smaller output size and then free scaling
		write_vset(12'd600);
		write_hset(1'b0, 12'd1000);
		random_ratio();
		settle_and_check();
		write_hset(1'b1, 12'd1000);
		settle_and_check();
		write_hset(1'b0, 12'd0);
		write_vset(12'd0);

		// arc1 is 4:3 and arc2 is an exact 1600x500 wider than the screen
		write_arc('{x: 13'd4, y: 13'd3}, '{x: 13'h1640, y: 13'h11F4});
		ar = '{x: 13'd1, y: 13'd0};
		settle_and_check();
		ar = '{x: 13'd2, y: 13'd0};
		settle_and_check();

		// Unknown opcode and then words with uio low
		begin_cmd(8'h55);
		send_word(16'd640);
		send_word(16'd480);
		end_cmd();
		send_word(16'h0027);
		send_word(16'd300);
		settle_and_check();

		if (sys_video_ctrl_i.sva_i.fail_count != 0) begin
			stop_run();
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: src.f
common/hps_cmd_pkg.sv
common/video_pkg.sv
hps_io/hps_cmd_decoder.sv
hps_io/video_cfg_regs.sv
video_window/umuldiv.sv
video_window/ar_window_fsm.sv
verilog/sys_video_ctrl.sv
verification/sys_video_ctrl_assertions.sv
verification/tb_sys_video_ctrl.sv

// File: Makefile
TOP := tb_sys_video_ctrl
OBJ := obj_dir

.PHONY: all run lint clean

all: run

run: $(OBJ)/V$(TOP)
	$(OBJ)/V$(TOP) +verilator+error+limit+100

$(OBJ)/V$(TOP): src.f $(shell cat src.f)
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir $(OBJ)

lint:
	verilator --lint-only --timing --assert -Wall -f src.f --top-module sys_video_ctrl

clean:
	rm -rf $(OBJ)
